//--- hw/lsu_axi_master.sv
// lsu bus master: runs one queued request on the AXI-lite channels and builds its result
`timescale 1ns/1ps
`default_nettype none

module lsu_axi_master import lsu_pkg::*; (
	input  wire          clock,
	input  wire          rstn,
	input  aligned_req_t req_i,
	input  wire          req_valid_i,
	output logic         req_ready_o,
	output bus_addr_t    ar_o,
	output logic         ar_valid_o,
	input  wire          ar_ready_i,
	output bus_addr_t    aw_o,
	output logic         aw_valid_o,
	input  wire          aw_ready_i,
	output bus_wdata_t   w_o,
	output logic         w_valid_o,
	input  wire          w_ready_i,
	input  bus_rdata_t   r_i,
	input  wire          r_valid_i,
	output logic         r_ready_o,
	input  resp_t        b_resp_i,
	input  wire          b_valid_i,
	output logic         b_ready_o,
	output lsu_result_t  result_o,
	output logic         result_valid_o,
	input  wire          result_ready_i
);

	typedef enum logic [1:0] {
		IDLE,
		ADDR,
		RESP,
		DONE
	} state_e;

	state_e       state, state_nxt;
	aligned_req_t req_q;
	logic         is_load;
	logic         aw_done;  // AW accepted, W may still be pending
	logic         w_done;
	logic         pop;
	logic         aw_hs, w_hs, ar_hs, r_hs, b_hs;
	logic         wr_sent;
	data_t        lane;
	data_t        load_data;

	function automatic logic is_load_op(mem_op_e op);
		return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
	endfunction

	assign is_load = is_load_op(req_q.op);

	assign req_ready_o    = (state == IDLE);
	assign result_valid_o = (state == DONE);
	assign pop            = req_valid_i && req_ready_o;

	assign ar_valid_o = (state == ADDR) && is_load;
	assign aw_valid_o = (state == ADDR) && !is_load && !aw_done;
	assign w_valid_o  = (state == ADDR) && !is_load && !w_done;
	assign r_ready_o  = (state == RESP) && is_load;
	assign b_ready_o  = (state == RESP) && !is_load;

	assign ar_o.addr = req_q.word_addr;
	assign aw_o.addr = req_q.word_addr;
	assign w_o.data  = req_q.wdata;
	assign w_o.strb  = req_q.strb;

	assign ar_hs = ar_valid_o && ar_ready_i;
	assign aw_hs = aw_valid_o && aw_ready_i;
	assign w_hs  = w_valid_o && w_ready_i;
	assign r_hs  = r_valid_i && r_ready_o;
	assign b_hs  = b_valid_i && b_ready_o;

	// both halves of the store delivered, in whatever order
	assign wr_sent = (aw_done || aw_hs) && (w_done || w_hs);

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: if (pop) state_nxt = req_i.misaligned ? DONE : ADDR;
			ADDR: if (is_load ? ar_hs : wr_sent) state_nxt = RESP;
			RESP: if (r_hs || b_hs) state_nxt = DONE;
			DONE: if (result_ready_i) state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state   <= IDLE;
			aw_done <= 1'b0;
			w_done  <= 1'b0;
		end else begin
			state <= state_nxt;
			if (pop) begin
				aw_done <= 1'b0;
				w_done  <= 1'b0;
			end else begin
				if (aw_hs) aw_done <= 1'b1;
				if (w_hs)  w_done  <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			req_q <= req_i;
		end
	end

	// bring the addressed lane down to bit 0, then extend by op
	always_comb begin
		lane = r_i.data >> {req_q.offset, 3'b000};
		case (req_q.op)
			OP_LB:   load_data = {{(XLEN-8){lane[7]}}, lane[7:0]};
			OP_LBU:  load_data = {{(XLEN-8){1'b0}}, lane[7:0]};
			OP_LH:   load_data = {{(XLEN-16){lane[15]}}, lane[15:0]};
			OP_LHU:  load_data = {{(XLEN-16){1'b0}}, lane[15:0]};
			default: load_data = lane;
		endcase
	end

	always_ff @(posedge clock) begin
		if (pop && req_i.misaligned) begin
			result_o.rd      <= req_i.rd;
			result_o.data    <= '0;
			result_o.is_load <= is_load_op(req_i.op);
			result_o.err     <= 1'b1; // never reaches the bus
		end else if (r_hs) begin
			result_o.rd      <= req_q.rd;
			result_o.data    <= (r_i.resp == RESP_OKAY) ? load_data : '0;
			result_o.is_load <= 1'b1;
			result_o.err     <= (r_i.resp != RESP_OKAY);
		end else if (b_hs) begin
			result_o.rd      <= req_q.rd;
			result_o.data    <= '0;
			result_o.is_load <= 1'b0;
			result_o.err     <= (b_resp_i != RESP_OKAY);
		end
	end

endmodule

`default_nettype wire

//--- hw/lsu_pkg.sv
// lsu shared package: widths, memory ops, request/result records and bus payloads
`default_nettype none

package lsu_pkg;

	localparam int XLEN       = 32;
	localparam int STRB_W     = XLEN / 8;
	localparam int MEM_WORDS  = 256;
	localparam int MEM_IDX_W  = $clog2(MEM_WORDS);
	localparam int FIFO_DEPTH = 2;
	localparam int FIFO_PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

	typedef logic [XLEN-1:0]   addr_t;
	typedef logic [XLEN-3:0]   word_addr_t; // byte address without the lane bits
	typedef logic [XLEN-1:0]   data_t;
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [4:0]        reg_idx_t;
	typedef logic [1:0]        resp_t;

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	typedef enum logic [2:0] {
		OP_LB,
		OP_LH,
		OP_LW,
		OP_LBU,
		OP_LHU,
		OP_SB,
		OP_SH,
		OP_SW
	} mem_op_e;

	// request as it comes from execute
	typedef struct packed {
		mem_op_e  op;
		addr_t    addr;
		data_t    wdata;
		reg_idx_t rd;
	} mem_req_t;

	// after lane formatting
	typedef struct packed {
		mem_op_e    op;
		word_addr_t word_addr;
		logic [1:0] offset;
		data_t      wdata;      // already shifted to its byte lane
		strb_t      strb;
		reg_idx_t   rd;
		logic       misaligned;
	} aligned_req_t;

	typedef struct packed {
		word_addr_t addr;
	} bus_addr_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
	} bus_wdata_t;

	typedef struct packed {
		data_t data;
		resp_t resp;
	} bus_rdata_t;

	// data is zero for stores and for errors
	typedef struct packed {
		reg_idx_t rd;
		data_t    data;
		logic     is_load;
		logic     err;
	} lsu_result_t;

endpackage

`default_nettype wire

//--- hw/lsu_req_fifo.sv
// lsu request queue: small circular buffer between formatter and bus master
`timescale 1ns/1ps
`default_nettype none

module lsu_req_fifo import lsu_pkg::*; (
	input  wire          clock,
	input  wire          rstn,
	input  aligned_req_t in_i,
	input  wire          in_valid_i,
	output logic         in_ready_o,
	output aligned_req_t out_o,
	output logic         out_valid_o,
	input  wire          out_ready_i
);

	aligned_req_t          mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count;
	logic                  full;
	logic                  push;
	logic                  pop;

	assign full        = (count == FIFO_CNT_W'(FIFO_DEPTH));
	assign out_valid_o = (count != '0);
	assign out_o       = mem[rd_ptr];

	// a full queue still takes a new entry when the head leaves
	assign in_ready_o = !full || out_ready_i;

	assign push = in_valid_i && in_ready_o;
	assign pop  = out_valid_o && out_ready_i;

	always_ff @(posedge clock) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= in_i;
		end
	end

endmodule

`default_nettype wire

//--- hw/lsu_sram_slave.sv
// word-addressed memory slave on AXI-lite style channels with byte strobes and range error
`timescale 1ns/1ps
`default_nettype none

module lsu_sram_slave import lsu_pkg::*; (
	input  wire        clock,
	input  wire        rstn,
	input  bus_addr_t  ar_i,
	input  wire        ar_valid_i,
	output logic       ar_ready_o,
	input  bus_addr_t  aw_i,
	input  wire        aw_valid_i,
	output logic       aw_ready_o,
	input  bus_wdata_t w_i,
	input  wire        w_valid_i,
	output logic       w_ready_o,
	output bus_rdata_t r_o,
	output logic       r_valid_o,
	input  wire        r_ready_i,
	output resp_t      b_resp_o,
	output logic       b_valid_o,
	input  wire        b_ready_i
);

	data_t      mem [MEM_WORDS];
	logic       resp_pend;
	logic       aw_got;     // address half of a write is in
	logic       w_got;
	bus_addr_t  aw_q;
	bus_wdata_t w_q;
	logic       ar_hs, aw_hs, w_hs;
	logic       wr_fire;
	word_addr_t wr_addr;
	bus_wdata_t wr_data;
	logic       rd_in_range;
	logic       wr_in_range;

	assign resp_pend  = r_valid_o || b_valid_o;
	assign ar_ready_o = !resp_pend;
	assign aw_ready_o = !resp_pend && !aw_got;
	assign w_ready_o  = !resp_pend && !w_got;

	assign ar_hs = ar_valid_i && ar_ready_o;
	assign aw_hs = aw_valid_i && aw_ready_o;
	assign w_hs  = w_valid_i && w_ready_o;

	assign wr_fire = (aw_got || aw_hs) && (w_got || w_hs);
	assign wr_addr = aw_got ? aw_q.addr : aw_i.addr;
	assign wr_data = w_got ? w_q : w_i;

	assign rd_in_range = (ar_i.addr < word_addr_t'(MEM_WORDS));
	assign wr_in_range = (wr_addr < word_addr_t'(MEM_WORDS));

	always_ff @(posedge clock) begin
		if (!rstn) begin
			r_valid_o <= 1'b0;
			b_valid_o <= 1'b0;
			aw_got    <= 1'b0;
			w_got     <= 1'b0;
		end else begin
			if (r_valid_o && r_ready_i) r_valid_o <= 1'b0;
			if (b_valid_o && b_ready_i) b_valid_o <= 1'b0;
			if (ar_hs) r_valid_o <= 1'b1;
			if (wr_fire) begin
				b_valid_o <= 1'b1;
				aw_got    <= 1'b0;
				w_got     <= 1'b0;
			end else begin
				if (aw_hs) aw_got <= 1'b1;
				if (w_hs)  w_got  <= 1'b1;
			end
		end
	end

	// storage is zeroed at reset
	always_ff @(posedge clock) begin
		if (!rstn) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_fire && wr_in_range) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (wr_data.strb[b]) begin
					mem[wr_addr[MEM_IDX_W-1:0]][8*b +: 8] <= wr_data.data[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (aw_hs) aw_q <= aw_i;
		if (w_hs)  w_q  <= w_i;
		if (ar_hs) begin
			r_o.data <= rd_in_range ? mem[ar_i.addr[MEM_IDX_W-1:0]] : '0;
			r_o.resp <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
		end
		if (wr_fire) begin
			b_resp_o <= wr_in_range ? RESP_OKAY : RESP_SLVERR; // write dropped when out of range
		end
	end

endmodule

`default_nettype wire

//--- hw/lsu_store_align.sv
// lsu request formatter: alignment check, store lane shift and byte strobes, one register stage
`timescale 1ns/1ps
`default_nettype none

module lsu_store_align import lsu_pkg::*; (
	input  wire          clock,
	input  wire          rstn,
	input  mem_req_t     req_i,
	input  wire          req_valid_i,
	output logic         req_ready_o,
	output aligned_req_t out_o,
	output logic         out_valid_o,
	input  wire          out_ready_i
);

	aligned_req_t fmt;
	logic [1:0]   offset;
	strb_t        base_strb;
	logic         misaligned;

	assign offset = req_i.addr[1:0];

	// halfwords need an even offset, words offset zero
	always_comb begin
		case (req_i.op)
			OP_LH, OP_LHU, OP_SH: misaligned = offset[0];
			OP_LW, OP_SW:         misaligned = |offset;
			default:              misaligned = 1'b0;
		endcase
	end

	// loads write nothing, so no strobe
	always_comb begin
		case (req_i.op)
			OP_SB:   base_strb = 4'b0001;
			OP_SH:   base_strb = 4'b0011;
			OP_SW:   base_strb = 4'b1111;
			default: base_strb = '0;
		endcase
	end

	always_comb begin
		fmt.op         = req_i.op;
		fmt.word_addr  = req_i.addr[XLEN-1:2];
		fmt.offset     = offset;
		fmt.wdata      = req_i.wdata << {offset, 3'b000}; // byte lanes
		fmt.strb       = base_strb << offset;
		fmt.rd         = req_i.rd;
		fmt.misaligned = misaligned;
	end

	// register empty or draining this cycle
	assign req_ready_o = !out_valid_o || out_ready_i;

	always_ff @(posedge clock) begin
		if (!rstn) begin
			out_valid_o <= 1'b0;
		end else if (req_ready_o) begin
			out_valid_o <= req_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		if (req_valid_i && req_ready_o) begin
			out_o <= fmt;
		end
	end

endmodule

`default_nettype wire

//--- hw/lsu_top.sv
// load/store unit top: formatter, request queue, bus master and memory slave
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
	input  wire         clock,
	input  wire         rstn,
	input  mem_req_t    req_i,
	input  wire         req_valid_i,
	output logic        req_ready_o,
	output lsu_result_t result_o,
	output logic        result_valid_o,
	input  wire         result_ready_i
);

	aligned_req_t fmt_req, q_req;
	logic         fmt_valid, fmt_ready;
	logic         q_valid, q_ready;
	bus_addr_t    ar, aw;
	bus_wdata_t   w;
	bus_rdata_t   r;
	resp_t        b_resp;
	logic         ar_valid, ar_ready;
	logic         aw_valid, aw_ready;
	logic         w_valid, w_ready;
	logic         r_valid, r_ready;
	logic         b_valid, b_ready;

	lsu_store_align u_align (
		.clock       (clock),
		.rstn        (rstn),
		.req_i       (req_i),
		.req_valid_i (req_valid_i),
		.req_ready_o (req_ready_o),
		.out_o       (fmt_req),
		.out_valid_o (fmt_valid),
		.out_ready_i (fmt_ready)
	);

	lsu_req_fifo u_fifo (
		.clock       (clock),
		.rstn        (rstn),
		.in_i        (fmt_req),
		.in_valid_i  (fmt_valid),
		.in_ready_o  (fmt_ready),
		.out_o       (q_req),
		.out_valid_o (q_valid),
		.out_ready_i (q_ready)
	);

	lsu_axi_master u_master (
		.clock (clock), .rstn (rstn),
		.req_i (q_req), .req_valid_i (q_valid), .req_ready_o (q_ready),
		.ar_o (ar), .ar_valid_o (ar_valid), .ar_ready_i (ar_ready),
		.aw_o (aw), .aw_valid_o (aw_valid), .aw_ready_i (aw_ready),
		.w_o (w), .w_valid_o (w_valid), .w_ready_i (w_ready),
		.r_i (r), .r_valid_i (r_valid), .r_ready_o (r_ready),
		.b_resp_i (b_resp), .b_valid_i (b_valid), .b_ready_o (b_ready),
		.result_o (result_o), .result_valid_o (result_valid_o),
		.result_ready_i (result_ready_i)
	);

	lsu_sram_slave u_sram (
		.clock (clock), .rstn (rstn),
		.ar_i (ar), .ar_valid_i (ar_valid), .ar_ready_o (ar_ready),
		.aw_i (aw), .aw_valid_i (aw_valid), .aw_ready_o (aw_ready),
		.w_i (w), .w_valid_i (w_valid), .w_ready_o (w_ready),
		.r_o (r), .r_valid_o (r_valid), .r_ready_i (r_ready),
		.b_resp_o (b_resp), .b_valid_o (b_valid), .b_ready_i (b_ready)
	);

endmodule

`default_nettype wire

//--- tb.f
hw/lsu_pkg.sv
hw/lsu_store_align.sv
hw/lsu_req_fifo.sv
hw/lsu_axi_master.sv
hw/lsu_sram_slave.sv
hw/lsu_top.sv
tests/lsu_props.sv
tests/lsu_tb.sv

//--- tests/lsu_props.sv
// handshake properties for the lsu bus master, bound in from the testbench
`timescale 1ns/1ps
`default_nettype none

module lsu_props import lsu_pkg::*; (
	input wire         clock,
	input wire         rstn,
	input bus_addr_t   ar_o,
	input wire         ar_valid_o,
	input wire         ar_ready_i,
	input wire         aw_valid_o,
	input wire         w_valid_o,
	input wire         r_valid_i,
	input wire         b_valid_i,
	input lsu_result_t result_o,
	input wire         result_valid_o,
	input wire         result_ready_i
);

	ar_stable: assert property (@(posedge clock) disable iff (!rstn)
		ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
		else $error("AR valid dropped or address changed before its handshake");

	// a store opens both write channels in the same cycle
	aw_w_together: assert property (@(posedge clock) disable iff (!rstn)
		$rose(aw_valid_o) == $rose(w_valid_o))
		else $error("AW valid and W valid did not rise together");

	result_hold: assert property (@(posedge clock) disable iff (!rstn)
		result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_o))
		else $error("result dropped or changed while writeback held it back");

	quiet_after_reset: assert property (@(posedge clock)
		$rose(rstn) |-> !ar_valid_o && !aw_valid_o && !w_valid_o && !r_valid_i && !b_valid_i)
		else $error("bus valid high in the first cycle after reset");

endmodule

`default_nettype wire

//--- tests/lsu_tb.sv
// directed testbench for the load/store unit with a byte-level memory model
`timescale 1ns/1ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

	localparam int TIMEOUT  = 200; // cycles per wait
	localparam int N_STREAM = 40;

	logic        clock;
	logic        rstn;
	mem_req_t    req;
	logic        req_valid;
	logic        req_ready;
	lsu_result_t result;
	logic        result_valid;
	logic        result_ready;

	logic [7:0]  mem_model [4*MEM_WORDS]; // expected memory with one byte per entry
	lsu_result_t exp_q [$];
	int unsigned errors;
	int unsigned timeouts;
	integer      seed;
	logic        stall_seen;    // req_ready seen low with a request waiting
	logic        stream_done;

	lsu_top dut_i (
		.clock          (clock),
		.rstn           (rstn),
		.req_i          (req),
		.req_valid_i    (req_valid),
		.req_ready_o    (req_ready),
		.result_o       (result),
		.result_valid_o (result_valid),
		.result_ready_i (result_ready)
	);

	bind lsu_axi_master lsu_props props_i (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic mem_req_t make_req(mem_op_e op, addr_t addr, data_t wdata, reg_idx_t rd);
		mem_req_t r;
		r.op    = op;
		r.addr  = addr;
		r.wdata = wdata;
		r.rd    = rd;
		return r;
	endfunction

	// expected result from the alignment, range, strobe and extension rules
	task automatic model_access(input mem_req_t r, output lsu_result_t exp);
		logic [1:0] off;
		word_addr_t word;
		logic       mis;
		int         idx;
		logic [7:0] b0;
		logic [7:0] b1;
		off         = r.addr[1:0];
		word        = r.addr[XLEN-1:2];
		exp.rd      = r.rd;
		exp.data    = '0;
		exp.is_load = !(r.op inside {OP_SB, OP_SH, OP_SW});
		exp.err     = 1'b0;
		case (r.op)
			OP_LH, OP_LHU, OP_SH: mis = off[0];
			OP_LW, OP_SW:         mis = (off != 2'd0);
			default:              mis = 1'b0;
		endcase
		if (mis || word >= word_addr_t'(MEM_WORDS)) begin
			exp.err = 1'b1;
			return;
		end
		idx = 4*int'(word) + int'(off);
		b0  = mem_model[idx];
		b1  = (off < 2'd3) ? mem_model[idx+1] : 8'h00;
		case (r.op)
			OP_LB:  exp.data = {{24{b0[7]}}, b0};
			OP_LBU: exp.data = {24'h0, b0};
			OP_LH:  exp.data = {{16{b1[7]}}, b1, b0};
			OP_LHU: exp.data = {16'h0, b1, b0};
			OP_LW:  exp.data = {mem_model[idx+3], mem_model[idx+2], b1, b0};
			OP_SB:  mem_model[idx] = r.wdata[7:0];
			OP_SH: begin
				mem_model[idx]   = r.wdata[7:0];
				mem_model[idx+1] = r.wdata[15:8];
			end
			default: begin // word store
				for (int b = 0; b < 4; b++) mem_model[idx+b] = r.wdata[8*b +: 8];
			end
		endcase
	endtask

	task automatic check_result(input string name, input lsu_result_t exp,
		input lsu_result_t act);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s: expected rd=%0d data=%h load=%b err=%b", name,
				exp.rd, exp.data, exp.is_load, exp.err);
			$display("MISMATCH %s: actual   rd=%0d data=%h load=%b err=%b", name,
				act.rd, act.data, act.is_load, act.err);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s: expected %b actual %b", name, exp, act);
		end
	endtask

	// hold the request until the edge where ready is high
	task automatic send_req(input mem_req_t r);
		int waited;
		waited = 0;
		@(posedge clock);
		req       <= r;
		req_valid <= 1'b1;
		@(negedge clock);
		while (!req_ready && waited < TIMEOUT) begin
			stall_seen = 1'b1;
			@(negedge clock);
			waited++;
		end
		if (!req_ready) begin
			timeouts++;
			$display("TIMEOUT: request to address %h was never accepted", r.addr);
		end
		@(posedge clock);
		req_valid <= 1'b0;
	endtask

	task automatic get_result(output lsu_result_t act, output logic ok);
		int waited;
		waited = 0;
		@(negedge clock);
		while (!(result_valid && result_ready) && waited < TIMEOUT) begin
			@(negedge clock);
			waited++;
		end
		ok  = result_valid && result_ready;
		act = result;
		if (!ok) begin
			timeouts++;
			$display("TIMEOUT: no result came out for the oldest request");
		end
		@(posedge clock); // transfer edge
	endtask

	task automatic do_access(input string name, input mem_req_t r);
		lsu_result_t exp;
		lsu_result_t act;
		logic        ok;
		model_access(r, exp);
		send_req(r);
		get_result(act, ok);
		if (ok) check_result(name, exp, act);
	endtask

	task automatic test_word_rw();
		do_access("word_store", make_req(OP_SW, 32'h10, 32'hdeadbeef, 5'd5));
		do_access("word_load", make_req(OP_LW, 32'h10, 32'h0, 5'd6));
	endtask

	task automatic test_sub_word();
		logic [7:0] bytes [4] = '{8'h81, 8'h12, 8'hf3, 8'h44};
		do_access("sub_fill", make_req(OP_SW, 32'h20, 32'ha5a5a5a5, 5'd1));
		for (int off = 0; off < 4; off++) begin
			do_access("sub_sb", make_req(OP_SB, 32'h20 + off, {24'hdeadbe, bytes[off]}, 5'd2));
			do_access("sub_lw_after_sb", make_req(OP_LW, 32'h20, 32'h0, 5'd3));
		end
		for (int off = 0; off < 4; off++) begin
			do_access("sub_lb", make_req(OP_LB, 32'h20 + off, 32'h0, 5'd4));
			do_access("sub_lbu", make_req(OP_LBU, 32'h20 + off, 32'h0, 5'd5));
		end
		do_access("sub_lh_bytes", make_req(OP_LH, 32'h22, 32'h0, 5'd6));
		do_access("half_fill", make_req(OP_SW, 32'h30, 32'h5a5a5a5a, 5'd7));
		do_access("half_sh_lo", make_req(OP_SH, 32'h30, 32'h12348001, 5'd8));
		for (int off = 0; off < 4; off += 2) begin
			do_access("half_lh", make_req(OP_LH, 32'h30 + off, 32'h0, 5'd9));
			do_access("half_lhu", make_req(OP_LHU, 32'h30 + off, 32'h0, 5'd10));
		end
		do_access("half_sh_hi", make_req(OP_SH, 32'h32, 32'hffff7ffe, 5'd11));
		do_access("half_lh_hi", make_req(OP_LH, 32'h32, 32'h0, 5'd12));
		do_access("half_lhu_hi", make_req(OP_LHU, 32'h32, 32'h0, 5'd13));
		do_access("half_lw", make_req(OP_LW, 32'h30, 32'h0, 5'd14));
	endtask

	task automatic test_misaligned();
		do_access("mis_fill", make_req(OP_SW, 32'h40, 32'h0badf00d, 5'd1));
		do_access("mis_lh", make_req(OP_LH, 32'h41, 32'h0, 5'd2));
		do_access("mis_lhu", make_req(OP_LHU, 32'h43, 32'h0, 5'd3));
		do_access("mis_sh", make_req(OP_SH, 32'h43, 32'hffffffff, 5'd4));
		do_access("mis_lw", make_req(OP_LW, 32'h42, 32'h0, 5'd5));
		do_access("mis_sw", make_req(OP_SW, 32'h41, 32'hffffffff, 5'd6));
		do_access("mis_unchanged", make_req(OP_LW, 32'h40, 32'h0, 5'd7));
	endtask

	task automatic test_out_of_range();
		addr_t top;
		top = addr_t'(4*MEM_WORDS);
		do_access("oor_lw", make_req(OP_LW, top, 32'h0, 5'd1));
		do_access("oor_sw", make_req(OP_SW, top, 32'hffffffff, 5'd2));
		do_access("oor_lb", make_req(OP_LB, top + 5, 32'h0, 5'd3));
		do_access("oor_sb", make_req(OP_SB, top + 6, 32'h000000ee, 5'd4));
		do_access("oor_sw_high", make_req(OP_SW, 32'hfffffff0, 32'h12345678, 5'd5));
		do_access("oor_alias_0", make_req(OP_LW, 32'h0, 32'h0, 5'd6));
		do_access("oor_alias_3f0", make_req(OP_LW, 32'h3f0, 32'h0, 5'd7));
		do_access("edge_sw", make_req(OP_SW, top - 4, 32'hcafe0123, 5'd8));
		do_access("edge_lw", make_req(OP_LW, top - 4, 32'h0, 5'd9));
	endtask

	task automatic test_stream();
		mem_req_t    reqs [N_STREAM];
		lsu_result_t exp;
		lsu_result_t act;
		logic        ok;
		logic [31:0] rnd;
		int          got;
		got         = 0;
		stall_seen  = 1'b0;
		stream_done = 1'b0;
		// model runs ahead since the DUT keeps request order
		for (int i = 0; i < N_STREAM; i++) begin
			rnd = $random(seed);
			reqs[i].op    = mem_op_e'(rnd[2:0]);
			reqs[i].rd    = rnd[14:10];
			reqs[i].wdata = $random(seed);
			case (reqs[i].op)
				OP_LB, OP_LBU, OP_SB: reqs[i].addr = {25'h0, rnd[7:3], rnd[9:8]};
				OP_LH, OP_LHU, OP_SH: reqs[i].addr = {25'h0, rnd[7:3], rnd[8], 1'b0};
				default:              reqs[i].addr = {25'h0, rnd[7:3], 2'b00};
			endcase
			model_access(reqs[i], exp);
			exp_q.push_back(exp);
		end
		fork
			begin // sender
				for (int i = 0; i < N_STREAM; i++) begin
					send_req(reqs[i]);
				end
			end
			begin // receiver
				for (int i = 0; i < N_STREAM; i++) begin
					get_result(act, ok);
					if (!ok) break;
					got++;
					check_result("stream", exp_q.pop_front(), act);
				end
				stream_done = 1'b1;
			end
			begin // writeback back-pressure
				for (int n = 0; n < N_STREAM * TIMEOUT && !stream_done; n++) begin
					@(posedge clock);
					rnd = $random(seed);
					result_ready <= (n < 20) ? 1'b0 : rnd[0]; // full stall first
				end
				@(posedge clock);
				result_ready <= 1'b1;
			end
		join
		if (got != N_STREAM) begin
			errors++;
			$display("ERROR: only %0d of %0d stream results came out", got, N_STREAM);
		end
		check_bit("stream_backpressure", 1'b1, stall_seen);
		exp_q.delete();
	endtask

	initial begin
		seed         = 32'hff6d;
		errors       = 0;
		timeouts     = 0;
		stall_seen   = 1'b0;
		stream_done  = 1'b0;
		rstn         = 1'b0;
		req          = '0;
		req_valid    = 1'b0;
		result_ready = 1'b1;
		for (int i = 0; i < 4*MEM_WORDS; i++) mem_model[i] = 8'h00;
		repeat (8) @(posedge clock);
		rstn <= 1'b1;
		@(negedge clock);
		check_bit("reset_req_ready", 1'b1, req_ready);
		check_bit("reset_result_valid", 1'b0, result_valid);
		test_word_rw();
		test_sub_word();
		test_misaligned();
		test_out_of_range();
		test_stream();
		repeat (4) @(posedge clock);
		$display("checks done: %0d mismatches or errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
